//--- fetch.sv
`timescale 1ns/1ps

module fetch import mem_pkg::*, fetch_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  logic          clock,
    input  logic          rst,
    input  logic          br_en,
    input  addr_t         target,
    input  logic          ibuff_open,
    output logic          out_valid,
    output fetch_bundle_t out_bundle,
    output addr_t         lookup_addr,
    input  logic          cache_hit,
    input  block_t        cache_block,
    input  logic          miss_pending,
    input  logic          mshr_full,
    input  logic          fill_done,
    output logic          mem_en,
    output mem_req_t      mem_addr,
    input  logic          mem_transaction_started
);

    fetch_state_e  state;
    fetch_state_e  next_state;
    addr_t         pc;

    // request register, holds the address steady until memory takes it
    logic          req_valid;
    mem_req_t      req_q;

    logic          accepted;
    logic          req_match;
    logic          miss_issue;
    logic          out_fire;
    logic          out_load;
    fetch_bundle_t next_bundle;

    assign lookup_addr = pc;
    assign mem_en      = req_valid;
    assign mem_addr    = req_q;

    assign accepted  = req_valid && mem_transaction_started;
    assign req_match = req_valid && (req_q.addr[31:3] == pc[31:3]);
    assign out_fire  = out_valid && ibuff_open;

    // output register is free when empty or draining this cycle
    assign out_load = (state == FS_RUN) && cache_hit && (!out_valid || ibuff_open);

    // miss handling
    always_comb begin
        next_state = state;
        miss_issue = 1'b0;
        if (state == FS_RUN) begin
            // with a fill landing now, just look up again next cycle
            // otherwise the fill we would wait for may be this very one
            if (!cache_hit && !fill_done && !br_en) begin
                if (miss_pending || (accepted && req_match)) begin
                    next_state = FS_WAIT_FILL;
                end else if (!req_valid && !mshr_full) begin
                    miss_issue = 1'b1;
                end
            end
        end else if (fill_done) begin
            // any fill may be ours, retry the lookup
            next_state = FS_RUN;
        end
    end

    // bundle from the hit block
    // aligned pc takes both words, odd-word pc only the upper one
    always_comb begin
        next_bundle = '0;
        if (!pc[2]) begin
            next_bundle.insts[0] = '{valid: 1'b1, pc: pc, inst: cache_block[31:0]};
            next_bundle.insts[1] = '{valid: 1'b1, pc: pc + 32'd4, inst: cache_block[63:32]};
            next_bundle.count    = 2'd2;
        end else begin
            next_bundle.insts[0] = '{valid: 1'b1, pc: pc, inst: cache_block[63:32]};
            next_bundle.count    = 2'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            pc        <= RESET_PC;
            state     <= FS_RUN;
            out_valid <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            // a request already on the bus survives a redirect
            if (accepted) begin
                req_valid <= 1'b0;
            end else if (miss_issue) begin
                req_valid <= 1'b1;
            end

            if (br_en) begin
                // redirect beats load and transfer
                pc        <= target;
                state     <= FS_RUN;
                out_valid <= 1'b0;
            end else begin
                state <= next_state;
                if (out_load) begin
                    out_valid <= 1'b1;
                    // pc runs ahead to the first word not yet fetched
                    pc <= pc + addr_t'({next_bundle.count, 2'b00});
                end else if (out_fire) begin
                    out_valid <= 1'b0;
                end
            end
        end
    end

    // payload registers
    always_ff @(posedge clock) begin
        if (miss_issue) begin
            req_q.addr <= {pc[31:3], 3'b000};
        end
        if (out_load && !br_en) begin
            out_bundle <= next_bundle;
        end
    end

endmodule

//--- fetch_pkg.sv
package fetch_pkg;

    import mem_pkg::*;

    // raw instruction word, fetch does not look inside it
    typedef logic [31:0] inst_t;

    // one fetched instruction with its own pc
    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } inst_packet_t;

    // up to two instructions per cycle toward the instruction buffer
    // insts[0] is oldest in program order
    // count is 1 or 2, insts[1] only valid when count is 2
    typedef struct packed {
        inst_packet_t [1:0] insts;
        logic [1:0]         count;
    } fetch_bundle_t;

    // fetch FSM
    typedef enum logic {
        FS_RUN,
        FS_WAIT_FILL
    } fetch_state_e;

endpackage

//--- fetch_unit.f
mem_pkg.sv
fetch_pkg.sv
icache.sv
mshr_table.sv
fetch.sv
fetch_unit.sv
fetch_unit_chk.sv
fetch_unit_tb.sv

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import mem_pkg::*, fetch_pkg::*; #(
    parameter int    NUM_MEM_TAGS = 16,
    parameter int    CACHE_LINES  = 32,
    parameter addr_t RESET_PC     = '0
) (
    input  logic          clock,
    input  logic          rst,
    input  logic          br_en,
    input  addr_t         target,
    input  logic          ibuff_open,
    output logic          mem_en,
    output mem_req_t      mem_addr,
    input  logic          mem_transaction_started,
    input  mem_tag_t      mem_transaction_tag,
    input  mem_tag_t      mem_data_tag,
    input  block_t        mem_data,
    output logic          out_valid,
    output fetch_bundle_t out_bundle
);

    // fetch <-> cache / miss table
    addr_t       lookup_addr;
    logic        cache_hit;
    block_t      cache_block;
    logic        miss_pending;
    logic        mshr_full;
    cache_fill_t fill;
    logic        fill_done;

    // pc, redirect, miss issue, output register
    fetch #(
        .RESET_PC (RESET_PC)
    ) fetch_0 (
        .clock                   (clock),
        .rst                     (rst),
        .br_en                   (br_en),
        .target                  (target),
        .ibuff_open              (ibuff_open),
        .out_valid               (out_valid),
        .out_bundle              (out_bundle),
        .lookup_addr             (lookup_addr),
        .cache_hit               (cache_hit),
        .cache_block             (cache_block),
        .miss_pending            (miss_pending),
        .mshr_full               (mshr_full),
        .fill_done               (fill_done),
        .mem_en                  (mem_en),
        .mem_addr                (mem_addr),
        .mem_transaction_started (mem_transaction_started)
    );

    icache #(
        .CACHE_LINES (CACHE_LINES)
    ) icache_0 (
        .clock       (clock),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .fill        (fill),
        .hit         (cache_hit),
        .block       (cache_block)
    );

    // tracks accepted requests by tag, turns responses into fills
    mshr_table #(
        .NUM_MEM_TAGS (NUM_MEM_TAGS)
    ) mshr_0 (
        .clock                   (clock),
        .rst                     (rst),
        .mem_transaction_started (mem_transaction_started),
        .mem_transaction_tag     (mem_transaction_tag),
        .mem_req                 (mem_addr),
        .mem_data_tag            (mem_data_tag),
        .mem_data                (mem_data),
        .lookup_addr             (lookup_addr),
        .pending                 (miss_pending),
        .full                    (mshr_full),
        .fill                    (fill),
        .fill_done               (fill_done)
    );

endmodule

//--- fetch_unit_chk.sv
`timescale 1ns/1ps

module fetch_unit_chk import mem_pkg::*, fetch_pkg::*; (
    input logic          clock,
    input logic          rst,
    input logic          br_en,
    input logic          ibuff_open,
    input logic          out_valid,
    input fetch_bundle_t out_bundle,
    input logic          mem_en,
    input logic          mshr_full,
    input fetch_state_e  fetch_state
);

    // a stalled bundle holds until taken, only a redirect may drop it
    bundle_stable: assert property (@(posedge clock) disable iff (rst)
        out_valid && !ibuff_open && !br_en |=> out_valid && $stable(out_bundle))
        else $error("output bundle changed under back-pressure");

    // no new miss while every tag is in flight
    no_req_when_full: assert property (@(posedge clock) disable iff (rst)
        !(mem_en && mshr_full))
        else $error("mem_en high with MSHR full");

    quiet_in_reset: assert property (@(posedge clock)
        rst && $past(rst) |-> !mem_en && !out_valid)
        else $error("outputs active during reset");

    pc_aligned: assert property (@(posedge clock) disable iff (rst)
        out_valid |-> out_bundle.insts[0].pc[1:0] == 2'b00
                      && (out_bundle.count != 2'd2 || out_bundle.insts[1].pc[1:0] == 2'b00))
        else $error("output pc not word aligned");

    // redirect empties the output and restarts the FSM
    redirect_flush: assert property (@(posedge clock) disable iff (rst)
        br_en |=> !out_valid && fetch_state == FS_RUN)
        else $error("redirect did not flush fetch");

endmodule

bind fetch_unit fetch_unit_chk chk_0 (
    .clock       (clock),
    .rst         (rst),
    .br_en       (br_en),
    .ibuff_open  (ibuff_open),
    .out_valid   (out_valid),
    .out_bundle  (out_bundle),
    .mem_en      (mem_en),
    .mshr_full   (mshr_full),
    .fetch_state (fetch_0.state)
);

//--- fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb import mem_pkg::*, fetch_pkg::*; ();

    localparam int CACHE_LINES = 32;

    logic          clock;
    logic          rst;
    logic          br_en;
    addr_t         target;
    logic          ibuff_open;
    logic          mem_en;
    mem_req_t      mem_addr;
    logic          mem_transaction_started;
    mem_tag_t      mem_transaction_tag;
    mem_tag_t      mem_data_tag;
    block_t        mem_data;
    logic          out_valid;
    fetch_bundle_t out_bundle;

    // memory model bookkeeping, one slot per tag
    logic [15:0]            tag_busy = '0;
    addr_t                  tag_addr [16];
    int                     tag_left [16];
    int                     lat_min = 2;
    int                     in_flight = 0;
    int                     max_in_flight = 0;
    int                     accepts = 0;

    // shadow of cache residency, index is block number modulo line count
    logic [CACHE_LINES-1:0] res_valid = '0;
    logic [28:0]            res_blk [CACHE_LINES];

    // scoreboard state
    addr_t                  exp_pc = '0;
    int                     packets = 0;

    fetch_unit #(
        .NUM_MEM_TAGS (16),
        .CACHE_LINES  (CACHE_LINES),
        .RESET_PC     ('0)
    ) DUT (
        .clock                   (clock),
        .rst                     (rst),
        .br_en                   (br_en),
        .target                  (target),
        .ibuff_open              (ibuff_open),
        .mem_en                  (mem_en),
        .mem_addr                (mem_addr),
        .mem_transaction_started (mem_transaction_started),
        .mem_transaction_tag     (mem_transaction_tag),
        .mem_data_tag            (mem_data_tag),
        .mem_data                (mem_data),
        .out_valid               (out_valid),
        .out_bundle              (out_bundle)
    );

    // memory image, each word is its own address scrambled
    function automatic inst_t ref_inst(input addr_t pc);
        return pc ^ 32'h5a3c_96e1;
    endfunction

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Verification failed");
        $fatal(1, "stopped after timeout");
    endtask

    // one packet against the expected pc, then step to the next word
    task automatic check_packet(input inst_packet_t p);
        check_equal(64'(p.valid), 64'(1), "packet valid bit");
        check_equal(64'(p.pc), 64'(exp_pc), "packet pc");
        check_equal(64'(p.inst), 64'(ref_inst(exp_pc)), "packet instruction");
        exp_pc = exp_pc + 32'd4;
        packets++;
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // memory model accepts after 0..3 cycles with a random free tag
    // and returns after lat_min..12 cycles, at most one response per cycle
    initial begin
        mem_tag_t   rsp_tag;
        mem_tag_t   new_tag;
        mem_tag_t   t;
        int         start;
        int         accept_wait;
        addr_t      blk;
        addr_t      req_first;
        logic [4:0] idx;
        accept_wait             = -1;
        req_first               = '0;
        mem_transaction_started = 1'b0;
        mem_transaction_tag     = '0;
        mem_data_tag            = '0;
        mem_data                = '0;
        forever begin
            @(posedge clock);
            #1;
            mem_transaction_started = 1'b0;
            mem_transaction_tag     = '0;
            mem_data_tag            = '0;
            rsp_tag                 = '0;
            new_tag                 = '0;
            if (!rst) begin
                // age every live transaction, lowest due tag goes first
                for (int i = 1; i < 16; i++) begin
                    t = mem_tag_t'(i);
                    if (tag_busy[t]) begin
                        if (tag_left[t] > 0) begin
                            tag_left[t]--;
                        end
                        if (tag_left[t] == 0 && rsp_tag == '0) begin
                            rsp_tag = t;
                        end
                    end
                end
                if (rsp_tag != '0) begin
                    blk               = tag_addr[rsp_tag];
                    idx               = 5'((blk >> 3) % CACHE_LINES);
                    mem_data_tag      = rsp_tag;
                    mem_data          = {ref_inst(blk + 32'd4), ref_inst(blk)};
                    tag_busy[rsp_tag] = 1'b0;
                    res_valid[idx]    = 1'b1;
                    res_blk[idx]      = blk[31:3];
                    in_flight--;
                end
                // a new request must name a whole block
                if (mem_en && accept_wait < 0) begin
                    accept_wait = $urandom % 4;
                    req_first   = mem_addr.addr;
                    check_equal(64'(mem_addr.addr[2:0]), 64'(0), "request address alignment");
                end
                // and keep naming it until memory takes it
                if (mem_en) begin
                    check_equal(64'(mem_addr.addr), 64'(req_first),
                                "request address while waiting");
                end
                if (mem_en && accept_wait == 0) begin
                    start = $urandom % 15;
                    for (int k = 0; k < 15; k++) begin
                        t = mem_tag_t'(1 + (start + k) % 15);
                        if (!tag_busy[t] && new_tag == '0) begin
                            new_tag = t;
                        end
                    end
                    if (new_tag != '0) begin
                        blk = mem_addr.addr;
                        idx = 5'((blk >> 3) % CACHE_LINES);
                        check_equal(64'(res_valid[idx] && res_blk[idx] == blk[31:3]), 64'(0),
                                    "request for a block still in the cache");
                        mem_transaction_started = 1'b1;
                        mem_transaction_tag     = new_tag;
                        tag_busy[new_tag]       = 1'b1;
                        tag_addr[new_tag]       = blk;
                        tag_left[new_tag]       = lat_min + $urandom % (13 - lat_min);
                        accept_wait             = -1;
                        accepts++;
                        in_flight++;
                        if (in_flight > max_in_flight) begin
                            max_in_flight = in_flight;
                        end
                    end
                end else if (accept_wait > 0) begin
                    accept_wait--;
                end
            end
        end
    end

    // comparison at mid cycle, where DUT outputs and driven inputs are settled
    always @(negedge clock) begin
        logic two;
        if (rst) begin
            check_equal(64'(out_valid), 64'(0), "out_valid during reset");
            check_equal(64'(mem_en), 64'(0), "mem_en during reset");
        end else if (br_en) begin
            exp_pc = target;
        end else if (out_valid && ibuff_open) begin
            two = !exp_pc[2];
            check_equal(64'(out_bundle.count), two ? 64'(2) : 64'(1), "bundle count");
            check_packet(out_bundle.insts[0]);
            if (two) begin
                check_packet(out_bundle.insts[1]);
            end
        end
    end

    // random back-pressure, optional random redirects, until goal packets seen
    task automatic run_until(input int goal, input int redirect_pct);
        int waited;
        waited = 0;
        while (packets < goal) begin
            @(posedge clock);
            #1;
            br_en      = 1'b0;
            ibuff_open = ($urandom % 4) != 0;
            if (($urandom % 100) < redirect_pct) begin
                br_en      = 1'b1;
                target     = ($urandom % 1024) << 2;
                ibuff_open = 1'b0;
            end
            waited++;
            if (waited > 20000) begin
                report_timeout("fetched instructions stopped arriving");
            end
        end
        @(posedge clock);
        #1;
        br_en = 1'b0;
    endtask

    task automatic redirect_to(input addr_t a);
        @(posedge clock);
        #1;
        br_en      = 1'b1;
        target     = a;
        ibuff_open = 1'b0;
        @(posedge clock);
        #1;
        br_en = 1'b0;
    endtask

    initial begin
        int idle;
        int waited;
        int acc0;
        void'($urandom(13));
        rst        = 1'b1;
        br_en      = 1'b0;
        target     = '0;
        ibuff_open = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        rst = 1'b0;

        // straight line from reset, then random redirects
        run_until(120, 0);
        run_until(packets + 300, 4);

        // back to back redirects to cold blocks with slow memory
        lat_min = 10;
        for (int k = 0; k < 6; k++) begin
            redirect_to(addr_t'(32'h4000_0000 + k * 256 + (k % 2) * 4));
            repeat (3) begin
                @(posedge clock);
                #1;
                ibuff_open = 1'b1;
            end
        end
        lat_min = 2;
        run_until(packets + 30, 0);

        // first pass over a short loop, then let memory go quiet
        redirect_to(32'h0000_8000);
        run_until(packets + 16, 0);
        idle   = 0;
        waited = 0;
        while (idle < 20) begin
            @(posedge clock);
            #1;
            ibuff_open = 1'b0;
            @(negedge clock);
            idle = (!mem_en && in_flight == 0) ? idle + 1 : 0;
            waited++;
            if (waited > 2000) begin
                report_timeout("memory traffic did not settle");
            end
        end

        // second pass hits only resident blocks
        acc0 = accepts;
        redirect_to(32'h0000_8000);
        run_until(packets + 12, 0);
        @(negedge clock);
        check_equal(64'(accepts - acc0), 64'(0), "requests made on loop revisit");
        check_equal(64'(max_in_flight >= 2), 64'(1), "never two misses in flight");
        $display("Verification passed");
        $finish;
    end

endmodule

//--- icache.sv
`timescale 1ns/1ps

module icache import mem_pkg::*; #(
    parameter int CACHE_LINES = 32
) (
    input  logic        clock,
    input  logic        rst,
    input  addr_t       lookup_addr,
    input  cache_fill_t fill,
    output logic        hit,
    output block_t      block
);

    // address splits into tag, index and a 3-bit block offset
    localparam int INDEX_BITS = $clog2(CACHE_LINES);
    localparam int TAG_BITS   = 32 - 3 - INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    // per-line state
    logic [CACHE_LINES-1:0] line_valid;
    tag_t                   line_tag  [CACHE_LINES];
    block_t                 line_data [CACHE_LINES];

    index_t lookup_index;
    tag_t   lookup_tag;
    index_t fill_index;
    tag_t   fill_tag;

    assign lookup_index = lookup_addr[3 +: INDEX_BITS];
    assign lookup_tag   = lookup_addr[31 -: TAG_BITS];
    assign fill_index   = fill.addr[3 +: INDEX_BITS];
    assign fill_tag     = fill.addr[31 -: TAG_BITS];

    // combinational read port
    // a fill in this cycle is not forwarded, it shows up next cycle
    assign hit   = line_valid[lookup_index] && (line_tag[lookup_index] == lookup_tag);
    assign block = line_data[lookup_index];

    // line valid bits
    always_ff @(posedge clock) begin
        if (rst) begin
            line_valid <= '0;
        end else if (fill.valid) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    // tag and data arrays
    // direct mapped, so a fill simply replaces whatever block held the index
    always_ff @(posedge clock) begin
        if (fill.valid) begin
            line_tag[fill_index]  <= fill_tag;
            line_data[fill_index] <= fill.data;
        end
    end

endmodule

//--- mem_pkg.sv
package mem_pkg;

    // byte address into instruction memory
    typedef logic [31:0] addr_t;

    // transaction tag handed back by memory
    // tag 0 never names a live transaction
    typedef logic [3:0] mem_tag_t;

    // one memory block holds two instruction words
    // word 0 sits in bits 31:0 and has the lower address
    typedef logic [63:0] block_t;

    // outgoing block request, qualified by mem_en
    // addr always has bits 2:0 clear
    typedef struct packed {
        addr_t addr;
    } mem_req_t;

    // line write from the miss table into the cache
    typedef struct packed {
        logic   valid;
        addr_t  addr;
        block_t data;
    } cache_fill_t;

endpackage

//--- mshr_table.sv
`timescale 1ns/1ps

module mshr_table import mem_pkg::*; #(
    parameter int NUM_MEM_TAGS = 16
) (
    input  logic        clock,
    input  logic        rst,
    input  logic        mem_transaction_started,
    input  mem_tag_t    mem_transaction_tag,
    input  mem_req_t    mem_req,
    input  mem_tag_t    mem_data_tag,
    input  block_t      mem_data,
    input  addr_t       lookup_addr,
    output logic        pending,
    output logic        full,
    output cache_fill_t fill,
    output logic        fill_done
);

    // one entry per memory tag
    // entry 0 exists only so the tag indexes directly, it is never allocated
    logic [NUM_MEM_TAGS-1:0] entry_valid;
    addr_t                   entry_addr [NUM_MEM_TAGS];

    logic alloc;
    logic rsp_hit;

    assign alloc = mem_transaction_started && (mem_transaction_tag != '0);

    // responses for tags we do not own are dropped
    assign rsp_hit = (mem_data_tag != '0) && entry_valid[mem_data_tag];

    // fill goes out in the response cycle itself
    assign fill.valid = rsp_hit;
    assign fill.addr  = entry_addr[mem_data_tag];
    assign fill.data  = mem_data;
    assign fill_done  = rsp_hit;

    // full when tags 1..N-1 are all in flight
    assign full = &entry_valid[NUM_MEM_TAGS-1:1];

    // block-level match against every live miss
    always_comb begin
        pending = 1'b0;
        for (int i = 1; i < NUM_MEM_TAGS; i++) begin
            if (entry_valid[i] && (entry_addr[i][31:3] == lookup_addr[31:3])) begin
                pending = 1'b1;
            end
        end
    end

    // allocate on acceptance, release on response
    // a tag freed and handed out again in one cycle ends up allocated
    always_ff @(posedge clock) begin
        if (rst) begin
            entry_valid <= '0;
        end else begin
            if (rsp_hit) begin
                entry_valid[mem_data_tag] <= 1'b0;
            end
            if (alloc) begin
                entry_valid[mem_transaction_tag] <= 1'b1;
            end
        end
    end

    // block address of each outstanding request
    always_ff @(posedge clock) begin
        if (alloc) begin
            entry_addr[mem_transaction_tag] <= mem_req.addr;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module fetch_unit_tb \
    -f fetch_unit.f -o fetch_unit_sim &&
./obj_dir/fetch_unit_sim || exit 1
